/* design/memPkg.sv */
package memPkg;

	////////////////////
	// Address map and sizes
	////////////////////

	// I/O window, word addressed on the bus
	localparam logic [31:0] ioRangeBase = 32'h0000_7F00;
	localparam logic [31:0] ioRangeTop = 32'h0000_7F1F;

	localparam int dmWords = 1024;
	localparam int dmAddrBits = $clog2(dmWords);

	localparam logic [31:0] resetPc = 32'h0000_3000;

	////////////////////
	// Encodings
	////////////////////

	typedef enum logic [3:0] {
		opNone,
		opLw,
		opLh,
		opLhu,
		opLb,
		opLbu,
		opSw,
		opSh,
		opSb,
		opAlu
	} memOp;

	typedef enum logic [2:0] {
		extWord,
		extHalfSigned,
		extHalfZero,
		extByteSigned,
		extByteZero
	} extOp;

	// MIPS cause codes
	typedef enum logic [4:0] {
		excNone = 5'd0,
		excAdEL = 5'd4,
		excAdES = 5'd5
	} excCode;

	////////////////////
	// Stage payloads
	////////////////////

	typedef struct packed {
		logic valid;
		memOp op;
		logic [31:0] aluOut;
		logic [31:0] storeData;
		logic [31:0] pc;
		logic [4:0] destReg;
		logic [2:0] tnew;
	} exToMemT;

	typedef struct packed {
		logic valid;
		logic [4:0] destReg;
		logic [31:0] pc;
		logic [31:0] aluOut;
		logic [31:0] readData;
		extOp ext;
		logic isLoad;
		logic [1:0] byteOff;
		logic [2:0] tnew;
		excCode exc;
	} memToWbT;

	typedef struct packed {
		logic [4:0] destReg;
		logic [2:0] tnew;
	} hazardT;

	typedef struct packed {
		logic write;
		logic [29:0] wordAddr;
		logic [31:0] wdata;
		logic [3:0] byteEn;
	} ioReqT;

	// Writeback register contents for an empty slot
	localparam memToWbT wbBubble = '{
		valid: 1'b0,
		destReg: 5'd0,
		pc: resetPc,
		aluOut: 32'd0,
		readData: 32'd0,
		ext: extWord,
		isLoad: 1'b0,
		byteOff: 2'd0,
		tnew: 3'd0,
		exc: excNone
	};

endpackage

/* design/accessDecode.sv */
`timescale 1ns/1ps

module accessDecode (
	input memPkg::memOp op,
	input logic [31:0] addr,
	output logic [3:0] byteEn,
	output memPkg::extOp ext,
	output logic isStore,
	output logic isLoad,
	output logic isIo,
	output memPkg::excCode exc
);
	import memPkg::*;

	logic isWord;
	logic isHalf;
	logic misaligned;
	logic inWindow;

	// Opcode classes and extension type
	always_comb
	begin
		isLoad = 1'b0;
		isStore = 1'b0;
		isWord = 1'b0;
		isHalf = 1'b0;
		ext = extWord;
		case (op)
			opLw:
			begin
				isLoad = 1'b1;
				isWord = 1'b1;
			end
			opLh:
			begin
				isLoad = 1'b1;
				isHalf = 1'b1;
				ext = extHalfSigned;
			end
			opLhu:
			begin
				isLoad = 1'b1;
				isHalf = 1'b1;
				ext = extHalfZero;
			end
			opLb:
			begin
				isLoad = 1'b1;
				ext = extByteSigned;
			end
			opLbu:
			begin
				isLoad = 1'b1;
				ext = extByteZero;
			end
			opSw:
			begin
				isStore = 1'b1;
				isWord = 1'b1;
			end
			opSh:
			begin
				isStore = 1'b1;
				isHalf = 1'b1;
			end
			opSb:
				isStore = 1'b1;
			default:
				isLoad = 1'b0;
		endcase
	end

	// Byte lanes from the low address bits
	always_comb
	begin
		if (isWord)
			byteEn = 4'b1111;
		else if (isHalf)
			byteEn = addr[1] ? 4'b1100 : 4'b0011;
		else if (isLoad || isStore)
			byteEn = 4'b0001 << addr[1:0];
		else
			byteEn = 4'b0000;
	end

	assign misaligned = (isWord && addr[1:0] != 2'b00) || (isHalf && addr[0]);
	assign inWindow = (addr >= ioRangeBase) && (addr <= ioRangeTop);
	assign isIo = (isLoad || isStore) && inWindow;

	assign exc = !misaligned ? excNone : (isStore ? excAdES : excAdEL);

endmodule

/* design/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory (
	input logic clk,
	input logic reset,
	input logic [memPkg::dmAddrBits-1:0] wordAddr,
	input logic [31:0] wdata,
	input logic [3:0] byteEn,
	input logic we,
	output logic [31:0] rdata
);
	import memPkg::*;

	logic [31:0] mem [dmWords];

	// Asynchronous read port
	assign rdata = mem[wordAddr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < dmWords; i++)
				mem[i] <= 32'd0;
		end
		else if (we)
		begin
			// Only the enabled lanes change
			for (int b = 0; b < 4; b++)
			begin
				if (byteEn[b])
					mem[wordAddr][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

endmodule

/* design/ioRequester.sv */
`timescale 1ns/1ps

module ioRequester (
	input logic clk,
	input logic reset,
	input logic start,
	input memPkg::ioReqT cmd,
	output logic busy,
	output logic done,
	output logic [31:0] rdata,
	output logic ioReq,
	input logic ioAck,
	output logic ioWrite,
	output logic [29:0] ioAddr,
	output logic [31:0] ioWData,
	output logic [3:0] ioByteEn,
	input logic [31:0] ioRData
);
	import memPkg::*;

	typedef enum logic [1:0] {
		stIdle,
		stRequest,
		stRelease,
		stFinish
	} ioState;

	ioState state;
	ioReqT cmdQ;

	////////////////////
	// Handshake FSM
	////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
			ioReq <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (start)
					begin
						ioReq <= 1'b1;
						state <= stRequest;
					end
				end
				stRequest:
				begin
					// Device has answered, drop the request
					if (ioAck)
					begin
						ioReq <= 1'b0;
						state <= stRelease;
					end
				end
				stRelease:
				begin
					if (!ioAck)
						state <= stFinish;
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	// Command held for the whole transfer, read data taken at ack
	always_ff @(posedge clk)
	begin
		if (state == stIdle && start)
			cmdQ <= cmd;
		if (state == stRequest && ioAck)
			rdata <= ioRData;
	end

	assign busy = state != stIdle;
	assign done = state == stFinish;

	assign ioWrite = cmdQ.write;
	assign ioAddr = cmdQ.wordAddr;
	assign ioWData = cmdQ.wdata;
	assign ioByteEn = cmdQ.byteEn;

endmodule

/* design/memStage.sv */
`timescale 1ns/1ps

module memStage (
	input logic clk,
	input logic reset,
	input memPkg::exToMemT exIn,
	input logic fwdFromWb,
	input logic [31:0] wbBypass,
	output logic stall,
	output memPkg::hazardT hazardOut,
	output memPkg::memToWbT wbOut,
	output logic ioStart,
	output memPkg::ioReqT ioCmd,
	input logic ioBusy,
	input logic ioDone,
	input logic [31:0] ioRData
);
	import memPkg::*;

	logic [3:0] byteEn;
	extOp ext;
	logic isStore;
	logic isLoad;
	logic isIo;
	excCode exc;
	logic fault;
	logic ioActive;
	logic memWe;
	logic [31:0] storeWord;
	logic [31:0] laneData;
	logic [31:0] dmRData;
	logic [31:0] readData;
	logic [2:0] tnewNext;
	memToWbT wbNext;

	accessDecode decode_i (
		.op(exIn.op),
		.addr(exIn.aluOut),
		.byteEn(byteEn),
		.ext(ext),
		.isStore(isStore),
		.isLoad(isLoad),
		.isIo(isIo),
		.exc(exc)
	);

	////////////////////
	// Store data
	////////////////////

	assign storeWord = fwdFromWb ? wbBypass : exIn.storeData;

	// Replicate narrow data so every lane carries it
	always_comb
	begin
		case (exIn.op)
			opSb: laneData = {4{storeWord[7:0]}};
			opSh: laneData = {2{storeWord[15:0]}};
			default: laneData = storeWord;
		endcase
	end

	assign fault = exc != excNone;
	assign ioActive = exIn.valid && isIo && !fault;
	assign memWe = exIn.valid && isStore && !isIo && !fault;

	// Hold earlier stages until the bus transfer completes
	assign ioStart = ioActive && !ioBusy;
	assign stall = ioActive && !ioDone;

	always_comb
	begin
		ioCmd.write = isStore;
		ioCmd.wordAddr = exIn.aluOut[31:2];
		ioCmd.wdata = laneData;
		ioCmd.byteEn = byteEn;
	end

	dataMemory dmem_i (
		.clk(clk),
		.reset(reset),
		.wordAddr(exIn.aluOut[dmAddrBits+1:2]),
		.wdata(laneData),
		.byteEn(byteEn),
		.we(memWe),
		.rdata(dmRData)
	);

	assign readData = isIo ? ioRData : dmRData;

	////////////////////
	// Hazard countdown
	////////////////////

	assign tnewNext = (exIn.tnew != 3'd0) ? exIn.tnew - 3'd1 : 3'd0;

	always_comb
	begin
		hazardOut.destReg = exIn.destReg;
		hazardOut.tnew = tnewNext;
	end

	// A faulting access keeps its pc and code but writes no register
	always_comb
	begin
		wbNext.valid = 1'b1;
		wbNext.destReg = fault ? 5'd0 : exIn.destReg;
		wbNext.pc = exIn.pc;
		wbNext.aluOut = exIn.aluOut;
		wbNext.readData = (isLoad && !fault) ? readData : 32'd0;
		wbNext.ext = ext;
		wbNext.isLoad = isLoad && !fault;
		wbNext.byteOff = exIn.aluOut[1:0];
		wbNext.tnew = fault ? 3'd0 : tnewNext;
		wbNext.exc = exc;
	end

	// Bubble while stalled so an instruction registers once
	always_ff @(posedge clk)
	begin
		if (reset || !exIn.valid || stall)
			wbOut <= wbBubble;
		else
			wbOut <= wbNext;
	end

endmodule

/* design/loadAlign.sv */
`timescale 1ns/1ps

module loadAlign (
	input memPkg::memToWbT wbIn,
	output logic [31:0] value
);
	import memPkg::*;

	logic [31:0] shifted;

	// Addressed byte or halfword moved down to bit 0
	assign shifted = wbIn.readData >> {wbIn.byteOff, 3'b000};

	always_comb
	begin
		if (!wbIn.isLoad)
			value = wbIn.aluOut;
		else
		begin
			case (wbIn.ext)
				extWord:
					value = wbIn.readData;
				extHalfSigned:
					value = {{16{shifted[15]}}, shifted[15:0]};
				extHalfZero:
					value = {16'd0, shifted[15:0]};
				extByteSigned:
					value = {{24{shifted[7]}}, shifted[7:0]};
				extByteZero:
					value = {24'd0, shifted[7:0]};
				default:
					value = wbIn.readData;
			endcase
		end
	end

endmodule

/* design/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem (
	input logic clk,
	input logic reset,
	input memPkg::exToMemT exIn,
	input logic fwdFromWb,
	input logic [31:0] wbBypass,
	output logic stall,
	output memPkg::hazardT hazardOut,
	output memPkg::memToWbT wbOut,
	output logic [31:0] wbValue,
	output logic ioReq,
	input logic ioAck,
	output logic ioWrite,
	output logic [29:0] ioAddr,
	output logic [31:0] ioWData,
	output logic [3:0] ioByteEn,
	input logic [31:0] ioRData
);
	import memPkg::*;

	logic ioStart;
	ioReqT ioCmd;
	logic ioBusy;
	logic ioDone;
	logic [31:0] ioReadData;

	memStage stage_i (
		.clk(clk),
		.reset(reset),
		.exIn(exIn),
		.fwdFromWb(fwdFromWb),
		.wbBypass(wbBypass),
		.stall(stall),
		.hazardOut(hazardOut),
		.wbOut(wbOut),
		.ioStart(ioStart),
		.ioCmd(ioCmd),
		.ioBusy(ioBusy),
		.ioDone(ioDone),
		.ioRData(ioReadData)
	);

	ioRequester io_i (
		.clk(clk),
		.reset(reset),
		.start(ioStart),
		.cmd(ioCmd),
		.busy(ioBusy),
		.done(ioDone),
		.rdata(ioReadData),
		.ioReq(ioReq),
		.ioAck(ioAck),
		.ioWrite(ioWrite),
		.ioAddr(ioAddr),
		.ioWData(ioWData),
		.ioByteEn(ioByteEn),
		.ioRData(ioRData)
	);

	// Writeback side extension
	loadAlign align_i (
		.wbIn(wbOut),
		.value(wbValue)
	);

endmodule

/* sim/ioDeviceModel.sv */
`timescale 1ns/1ps

module ioDeviceModel (
	input logic clk,
	input logic reset,
	input logic [3:0] ackDelay,
	input logic ioReq,
	output logic ioAck,
	input logic ioWrite,
	input logic [29:0] ioAddr,
	input logic [31:0] ioWData,
	input logic [3:0] ioByteEn,
	output logic [31:0] ioRData
);
	// Eight word registers cover the 32-byte window
	logic [31:0] regs [8];
	logic [3:0] waitCount;
	logic [2:0] index;

	assign index = ioAddr[2:0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ioAck <= 1'b0;
			ioRData <= 32'd0;
			waitCount <= 4'd0;
			for (int i = 0; i < 8; i++)
				regs[i] <= 32'd0;
		end
		else if (ioReq && !ioAck)
		begin
			// Answer once the programmed delay has run out
			if (waitCount >= ackDelay)
			begin
				for (int b = 0; b < 4; b++)
				begin
					if (ioWrite && ioByteEn[b])
						regs[index][8*b +: 8] <= ioWData[8*b +: 8];
				end
				ioRData <= regs[index];
				ioAck <= 1'b1;
				waitCount <= 4'd0;
			end
			else
				waitCount <= waitCount + 4'd1;
		end
		else if (!ioReq && ioAck)
			ioAck <= 1'b0;
	end

endmodule

/* sim/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb;
	import memPkg::*;

	logic clk = 1'b0;
	logic reset;
	exToMemT exIn;
	logic fwdFromWb;
	logic [31:0] wbBypass;
	logic stall;
	hazardT hazardOut;
	memToWbT wbOut;
	logic [31:0] wbValue;
	logic ioReq;
	logic ioAck;
	logic ioWrite;
	logic [29:0] ioAddr;
	logic [31:0] ioWData;
	logic [3:0] ioByteEn;
	logic [31:0] ioRData;
	logic [3:0] ackDelay;

	int checkCount = 0;
	int mismatchCount = 0;
	int failCount = 0;
	int waitLimit = 64;
	logic [31:0] pcCount;
	memToWbT lastWb;
	hazardT lastHazard;
	logic [31:0] lastValue;
	int lastCycles;
	// Byte image of the data memory, little endian
	logic [7:0] refMem [4096];

	always #50 clk = ~clk;

	memSubsystem dut_i (
		.clk(clk),
		.reset(reset),
		.exIn(exIn),
		.fwdFromWb(fwdFromWb),
		.wbBypass(wbBypass),
		.stall(stall),
		.hazardOut(hazardOut),
		.wbOut(wbOut),
		.wbValue(wbValue),
		.ioReq(ioReq),
		.ioAck(ioAck),
		.ioWrite(ioWrite),
		.ioAddr(ioAddr),
		.ioWData(ioWData),
		.ioByteEn(ioByteEn),
		.ioRData(ioRData)
	);

	ioDeviceModel device_i (
		.clk(clk),
		.reset(reset),
		.ackDelay(ackDelay),
		.ioReq(ioReq),
		.ioAck(ioAck),
		.ioWrite(ioWrite),
		.ioAddr(ioAddr),
		.ioWData(ioWData),
		.ioByteEn(ioByteEn),
		.ioRData(ioRData)
	);

	////////////////////
	// Compare tasks
	////////////////////

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkExc(input string name, input excCode got, input excCode exp);
		checkCount++;
		if (got !== exp)
		begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(),
				exp.name());
		end
	endtask

	task automatic checkHazard(input string name, input hazardT got, input hazardT exp);
		checkCount++;
		if (got !== exp)
		begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got reg %0d tnew %0d expected reg %0d tnew %0d",
				$time, name, got.destReg, got.tnew, exp.destReg, exp.tnew);
		end
	endtask

	task automatic finishRun();
		$display("Checks: %0d, mismatches: %0d, other errors: %0d", checkCount, mismatchCount,
			failCount);
		if (mismatchCount == 0 && failCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic timeoutFail(input string what);
		failCount++;
		$display("Timeout at %0t while waiting for %s", $time, what);
		finishRun();
	endtask

	////////////////////
	// Reference model
	////////////////////

	function automatic logic [31:0] extendLoad(input memOp op, input logic [31:0] word,
		input logic [1:0] off);
		logic [7:0] b;
		logic [15:0] h;
		b = word[8 * int'(off) +: 8];
		h = off[1] ? word[31:16] : word[15:0];
		case (op)
			opLh: return {{16{h[15]}}, h};
			opLhu: return {16'd0, h};
			opLb: return {{24{b[7]}}, b};
			opLbu: return {24'd0, b};
			default: return word;
		endcase
	endfunction

	function automatic logic [31:0] refWord(input logic [31:0] addr);
		logic [11:0] a;
		a = {addr[11:2], 2'b00};
		return {refMem[a + 12'd3], refMem[a + 12'd2], refMem[a + 12'd1], refMem[a]};
	endfunction

	task automatic updateRef(input memOp op, input logic [31:0] addr, input logic [31:0] data);
		logic [11:0] a;
		a = addr[11:0];
		case (op)
			opSw:
			begin
				refMem[a] = data[7:0];
				refMem[a + 12'd1] = data[15:8];
				refMem[a + 12'd2] = data[23:16];
				refMem[a + 12'd3] = data[31:24];
			end
			opSh:
			begin
				refMem[a] = data[7:0];
				refMem[a + 12'd1] = data[15:8];
			end
			opSb:
				refMem[a] = data[7:0];
			default:
				refMem[a] = refMem[a];
		endcase
	endtask

	////////////////////
	// Drive tasks
	////////////////////

	// Present one instruction, hold it through any stall, then take the result
	task automatic issue(input memOp op, input logic [31:0] addr, input logic [31:0] data,
		input logic [2:0] tnew);
		exToMemT instr;
		int waited;
		instr.valid = 1'b1;
		instr.op = op;
		instr.aluOut = addr;
		instr.storeData = data;
		instr.pc = pcCount;
		instr.destReg = 5'd9;
		instr.tnew = tnew;
		pcCount = pcCount + 32'd4;
		@(posedge clk);
		exIn <= instr;
		@(negedge clk);
		lastHazard = hazardOut;
		lastCycles = 1;
		waited = 0;
		while (stall && waited < waitLimit)
		begin
			if (wbOut.valid)
			begin
				failCount++;
				$display("wbOut.valid was high during a stall at %0t", $time);
			end
			waited++;
			lastCycles++;
			@(negedge clk);
		end
		if (stall)
			timeoutFail("stall to drop");
		@(posedge clk);
		exIn <= '0;
		waited = 0;
		@(negedge clk);
		while (!wbOut.valid && waited < waitLimit)
		begin
			waited++;
			@(negedge clk);
		end
		if (!wbOut.valid)
			timeoutFail("wbOut.valid");
		else if (waited != 0)
		begin
			failCount++;
			$display("wbOut.valid arrived %0d cycles late at %0t", waited, $time);
		end
		lastWb = wbOut;
		lastValue = wbValue;
		checkWord("wbOut.pc", wbOut.pc, instr.pc);
	endtask

	task automatic expectOneCycle(input string what);
		if (lastCycles != 1)
		begin
			failCount++;
			$display("%s took %0d cycles instead of one at %0t", what, lastCycles, $time);
		end
	endtask

	task automatic storeOp(input memOp op, input logic [31:0] addr, input logic [31:0] data);
		issue(op, addr, data, 3'd0);
		checkExc("wbOut.exc", lastWb.exc, excNone);
		expectOneCycle("Store");
		updateRef(op, addr, data);
	endtask

	task automatic loadOp(input memOp op, input logic [31:0] addr);
		issue(op, addr, 32'd0, 3'd2);
		checkExc("wbOut.exc", lastWb.exc, excNone);
		expectOneCycle("Load");
		checkWord("wbValue", lastValue, extendLoad(op, refWord(addr), addr[1:0]));
	endtask

	// No second result may follow a finished access
	task automatic watchQuiet();
		repeat (4)
		begin
			@(negedge clk);
			if (wbOut.valid)
			begin
				failCount++;
				$display("Extra wbOut.valid after an I/O access at %0t", $time);
			end
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic testReset();
		checkWord("wbOut.valid", 32'(wbOut.valid), 32'd0);
		checkWord("wbOut.pc", wbOut.pc, resetPc);
		checkWord("ioReq", 32'(ioReq), 32'd0);
		checkWord("stall", 32'(stall), 32'd0);
	endtask

	task automatic testStoreLoad();
		storeOp(opSw, 32'h100, 32'h8765_43A1);
		storeOp(opSh, 32'h106, 32'hFFFF_F00D);
		storeOp(opSh, 32'h104, 32'h0000_7FFE);
		storeOp(opSb, 32'h108, 32'h0000_0080);
		storeOp(opSb, 32'h109, 32'h0000_007F);
		storeOp(opSb, 32'h10B, 32'h0000_00C3);
		storeOp(opSb, 32'h101, 32'h0000_0055);
		loadOp(opLw, 32'h100);
		loadOp(opLw, 32'h104);
		loadOp(opLw, 32'h108);
		loadOp(opLh, 32'h102);
		loadOp(opLhu, 32'h102);
		loadOp(opLh, 32'h104);
		loadOp(opLh, 32'h106);
		loadOp(opLhu, 32'h106);
		loadOp(opLb, 32'h100);
		loadOp(opLbu, 32'h100);
		loadOp(opLb, 32'h108);
		loadOp(opLbu, 32'h108);
		loadOp(opLb, 32'h109);
		loadOp(opLb, 32'h10A);
		loadOp(opLbu, 32'h10B);
	endtask

	task automatic testForward();
		@(posedge clk);
		fwdFromWb <= 1'b1;
		wbBypass <= 32'hCAFE_BABE;
		issue(opSw, 32'h200, 32'h1111_1111, 3'd0);
		updateRef(opSw, 32'h200, 32'hCAFE_BABE);
		@(posedge clk);
		wbBypass <= 32'h0000_00E7;
		issue(opSb, 32'h205, 32'h2222_2222, 3'd0);
		updateRef(opSb, 32'h205, 32'h0000_00E7);
		@(posedge clk);
		fwdFromWb <= 1'b0;
		loadOp(opLw, 32'h200);
		loadOp(opLw, 32'h204);
	endtask

	task automatic testMisaligned();
		storeOp(opSw, 32'h300, 32'h5A5A_5A5A);
		issue(opLw, 32'h302, 32'd0, 3'd2);
		checkExc("wbOut.exc", lastWb.exc, excAdEL);
		checkWord("wbOut.destReg", 32'(lastWb.destReg), 32'd0);
		issue(opLh, 32'h303, 32'd0, 3'd2);
		checkExc("wbOut.exc", lastWb.exc, excAdEL);
		issue(opSh, 32'h301, 32'h0000_1234, 3'd0);
		checkExc("wbOut.exc", lastWb.exc, excAdES);
		checkWord("wbOut.destReg", 32'(lastWb.destReg), 32'd0);
		// Faulting store in the I/O window must not reach the bus
		issue(opSw, 32'h7F01, 32'h0BAD_0BAD, 3'd0);
		checkExc("wbOut.exc", lastWb.exc, excAdES);
		expectOneCycle("Faulting I/O store");
		loadOp(opLw, 32'h300);
	endtask

	task automatic testIo();
		@(posedge clk);
		ackDelay <= 4'($urandom_range(7, 1));
		issue(opSw, 32'h7F08, 32'hDEAD_BEEF, 3'd0);
		checkExc("wbOut.exc", lastWb.exc, excNone);
		if (lastCycles < 2)
		begin
			failCount++;
			$display("I/O store did not stall at %0t", $time);
		end
		checkWord("device reg 2", device_i.regs[2], 32'hDEAD_BEEF);
		// Bus word address of byte address 0x7F08
		checkWord("ioAddr", 32'(ioAddr), 32'h0000_1FC2);
		watchQuiet();
		@(posedge clk);
		ackDelay <= 4'($urandom_range(7, 1));
		issue(opLw, 32'h7F08, 32'd0, 3'd2);
		if (lastCycles < 2)
		begin
			failCount++;
			$display("I/O load did not stall at %0t", $time);
		end
		checkWord("wbValue", lastValue, 32'hDEAD_BEEF);
		watchQuiet();
		@(posedge clk);
		ackDelay <= 4'($urandom_range(7, 1));
		issue(opLb, 32'h7F0A, 32'd0, 3'd2);
		checkWord("wbValue", lastValue, extendLoad(opLb, 32'hDEAD_BEEF, 2'd2));
		checkWord("ioWrite", 32'(ioWrite), 32'd0);
		checkWord("ioByteEn", 32'(ioByteEn), 32'h0000_0004);
		watchQuiet();
		checkWord("ioReq", 32'(ioReq), 32'd0);
	endtask

	task automatic testHazard();
		logic [2:0] tnewSet [3];
		logic [2:0] tnewExp [3];
		hazardT expHz;
		tnewSet = '{3'd0, 3'd1, 3'd3};
		tnewExp = '{3'd0, 3'd0, 3'd2};
		for (int k = 0; k < 3; k++)
		begin
			expHz.destReg = 5'd9;
			expHz.tnew = tnewExp[k];
			issue(opAlu, 32'h1234_5600 + 32'(k), 32'd0, tnewSet[k]);
			checkHazard("hazardOut", lastHazard, expHz);
			checkWord("wbValue", lastValue, 32'h1234_5600 + 32'(k));
		end
	endtask

	initial
	begin
		void'($urandom(32'h854e74cc));
		reset <= 1'b1;
		exIn <= '0;
		fwdFromWb <= 1'b0;
		wbBypass <= 32'd0;
		ackDelay <= 4'd1;
		pcCount = 32'h0040_0000;
		for (int i = 0; i < 4096; i++)
			refMem[i] = 8'd0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		testReset();
		testStoreLoad();
		testForward();
		testMisaligned();
		testIo();
		testHazard();
		finishRun();
	end

endmodule

/* tb.f */
design/memPkg.sv
design/accessDecode.sv
design/dataMemory.sv
design/ioRequester.sv
design/memStage.sv
design/loadAlign.sv
design/memSubsystem.sv
sim/ioDeviceModel.sv
sim/memSubsystemTb.sv

/* Makefile */
TOOL := verilator
FLAGS := --binary --timing -j 0
TOP := memSubsystemTb
FILELIST := tb.f
BUILD := obj_dir
LOG := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
